// ==== Makefile ====
# Verilator build and run for the SpMM testbench

VERILATOR ?= verilator
TOP       ?= tb_spmm
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard testbench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/node_info_fifo.sv ====
`timescale 1ns/1ps

module node_info_fifo
  import spmm_dims_pkg::*;
  import spmm_layout_pkg::*;
#(
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  logic [NODE_INFO_W-1:0] din_i,
  input  logic                   pop_i,
  output logic [NODE_INFO_W-1:0] dout_o,
  output logic                   empty_o,
  output logic                   full_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [NODE_INFO_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       cnt_q;
  logic                   do_push;
  logic                   do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(FIFO_DEPTH));

  // Show-ahead read so the tag is there in the pop cycle
  assign dout_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // No more than two rows in flight, so a full FIFO means lost tags
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full_o);

  // Every finished row finds its tag waiting
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o);

endmodule

// ==== hdl/sparse_pe.sv ====
`timescale 1ns/1ps

module sparse_pe
  import spmm_dims_pkg::*;
#(
  parameter int DATA_WIDTH    = DEF_DATA_WIDTH,
  parameter int WH_DATA_WIDTH = DEF_WH_DATA_WIDTH
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            entry_vld_i,
  input  logic                            entry_first_i,
  input  logic                            entry_last_i,
  input  logic signed [DATA_WIDTH-1:0]    val_i,
  input  logic signed [DATA_WIDTH-1:0]    wgt_i,
  output logic                            res_vld_o,
  output logic signed [WH_DATA_WIDTH-1:0] res_o
);

  logic signed [DATA_WIDTH-1:0]    val_q;
  logic signed [2*DATA_WIDTH-1:0]  prod;
  logic signed [WH_DATA_WIDTH-1:0] prod_ext;
  logic signed [WH_DATA_WIDTH-1:0] acc_base;
  logic signed [WH_DATA_WIDTH-1:0] acc_q;

  // Value comes from the entry read, one cycle ahead of its weight
  always_ff @(posedge clk) begin
    val_q <= val_i;
  end

  assign prod     = val_q * wgt_i;
  assign prod_ext = prod;
  // First entry of a row drops the previous sum
  assign acc_base = entry_first_i ? '0 : acc_q;

  always_ff @(posedge clk) begin
    if (entry_vld_i) begin
      acc_q <= acc_base + prod_ext;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld_o <= 1'b0;
    end else begin
      res_vld_o <= entry_vld_i && entry_last_i;
    end
  end

  // Sum holds for one cycle only when the next row starts right away
  assign res_o = acc_q;

endmodule

// ==== hdl/spmm_ctrl.sv ====
`timescale 1ns/1ps

module spmm_ctrl
  import spmm_dims_pkg::*;
  import spmm_layout_pkg::*;
#(
  parameter int NUM_FEATURE_IN = DEF_NUM_FEATURE_IN,
  parameter int NUM_ROWS       = DEF_NUM_ROWS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_req_i,
  output logic                        start_ack_o,
  output logic [$clog2(NUM_ROWS)-1:0] ni_addr_o,
  input  logic [NODE_INFO_W-1:0]      ni_data_i,
  output logic [H_ADDR_W-1:0]         h_addr_o,
  output logic [COL_IDX_W-1:0]        w_row_addr_o,
  input  logic [ENTRY_W-1:0]          h_data_i,
  output logic                        entry_vld_o,
  output logic                        entry_first_o,
  output logic                        entry_last_o,
  output logic                        fifo_push_o,
  output logic [NODE_INFO_W-1:0]      fifo_din_o,
  output logic                        fifo_pop_o,
  input  logic                        row_done_i
);

  localparam int ROW_W = $clog2(NUM_ROWS);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RUN  = 2'd1;
  localparam logic [1:0] ST_ACK  = 2'd2;

  logic [1:0]           state_q;
  logic                 pre_q;
  logic                 feed_q;
  logic [ROW_W-1:0]     ni_addr_q;
  logic [ROW_W-1:0]     iss_row_q;
  logic [ROW_W-1:0]     done_row_q;
  logic [H_ADDR_W-1:0]  ent_addr_q;
  logic [ROW_LEN_W-1:0] pos_q;
  logic [ROW_LEN_W-1:0] cur_len_q;
  logic [ROW_LEN_W-1:0] ni_len;
  logic [ROW_LEN_W-1:0] row_len;
  logic                 run_go;
  logic                 issue;
  logic                 row_first;
  logic                 row_last;
  logic                 final_row;
  logic                 final_done;
  logic                 vld_d1;
  logic                 first_d1;
  logic                 last_d1;

  // ====================
  // Entry issue decode
  // ====================
  assign run_go     = (state_q == ST_IDLE) && start_req_i;
  assign issue      = (state_q == ST_RUN) && feed_q && !pre_q;
  assign ni_len     = ni_data_i[NI_LEN_LSB +: ROW_LEN_W];
  assign row_first  = (pos_q == '0);
  // At a row start the length comes straight from the prefetched word
  assign row_len    = row_first ? ni_len : cur_len_q;
  assign row_last   = ((pos_q + 1'b1) == row_len);
  assign final_row  = (iss_row_q == ROW_W'(NUM_ROWS - 1));
  assign final_done = row_done_i && (done_row_q == ROW_W'(NUM_ROWS - 1));

  assign ni_addr_o    = ni_addr_q;
  assign h_addr_o     = ent_addr_q;
  assign w_row_addr_o = h_data_i[ENT_COL_LSB +: COL_IDX_W];
  assign start_ack_o  = (state_q == ST_ACK);
  assign fifo_pop_o   = row_done_i && (state_q == ST_RUN);

  // ====================
  // Handshake FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      pre_q      <= 1'b0;
      feed_q     <= 1'b0;
      done_row_q <= '0;
    end else begin
      pre_q <= run_go;
      case (state_q)
        ST_IDLE: begin
          if (start_req_i) begin
            state_q    <= ST_RUN;
            feed_q     <= 1'b1;
            done_row_q <= '0;
          end
        end
        ST_RUN: begin
          if (issue && row_last && final_row) begin
            feed_q <= 1'b0;
          end
          if (row_done_i) begin
            done_row_q <= done_row_q + 1'b1;
          end
          if (final_done) begin
            state_q <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!start_req_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Row and entry pointers
  // ni_addr runs one row ahead so back-to-back rows need no bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ni_addr_q  <= '0;
      iss_row_q  <= '0;
      ent_addr_q <= '0;
      pos_q      <= '0;
      cur_len_q  <= '0;
    end else if (run_go) begin
      ni_addr_q  <= '0;
      iss_row_q  <= '0;
      ent_addr_q <= '0;
      pos_q      <= '0;
    end else if (pre_q) begin
      ni_addr_q <= ni_addr_q + 1'b1;
    end else if (issue) begin
      ent_addr_q <= ent_addr_q + 1'b1;
      if (row_first) begin
        cur_len_q <= ni_len;
      end
      if (row_last) begin
        pos_q     <= '0;
        iss_row_q <= iss_row_q + 1'b1;
        ni_addr_q <= ni_addr_q + 1'b1;
      end else begin
        pos_q <= pos_q + 1'b1;
      end
    end
  end

  // Flags follow the entry through the entry read and the weight read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_d1        <= 1'b0;
      first_d1      <= 1'b0;
      last_d1       <= 1'b0;
      entry_vld_o   <= 1'b0;
      entry_first_o <= 1'b0;
      entry_last_o  <= 1'b0;
      fifo_push_o   <= 1'b0;
    end else begin
      vld_d1        <= issue;
      first_d1      <= issue && row_first;
      last_d1       <= issue && row_last;
      entry_vld_o   <= vld_d1;
      entry_first_o <= first_d1;
      entry_last_o  <= last_d1;
      fifo_push_o   <= issue && row_first;
    end
  end

  always_ff @(posedge clk) begin
    if (issue && row_first) begin
      fifo_din_o <= ni_data_i;
    end
  end

  // Rows from the node-info memory are never empty and never wider than H
  a_row_len: assert property (@(posedge clk) disable iff (!rst_n)
    issue && row_first |-> (ni_len != '0) && (ni_len <= ROW_LEN_W'(NUM_FEATURE_IN)));

  // Requester holds req for the whole run
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ST_RUN) |-> start_req_i);

endmodule

// ==== hdl/spmm_dims_pkg.sv ====
package spmm_dims_pkg;

  // ====================
  // Default dimensions
  // ====================

  // Signed values and weights
  localparam int DEF_DATA_WIDTH      = 8;
  // One accumulated result
  localparam int DEF_WH_DATA_WIDTH   = 20;

  // Columns of H and of W
  localparam int DEF_NUM_FEATURE_IN  = 16;
  localparam int DEF_NUM_FEATURE_OUT = 4;

  localparam int DEF_NUM_ROWS        = 8;
  localparam int DEF_NNZ_DEPTH       = 64;
  localparam int DEF_MAX_NODES       = 15;
  localparam int DEF_FIFO_DEPTH      = 4;

  // Entry memory address
  localparam int H_ADDR_W = $clog2(DEF_NNZ_DEPTH);

endpackage

// ==== hdl/spmm_layout_pkg.sv ====
package spmm_layout_pkg;

  import spmm_dims_pkg::*;

  // ====================
  // Field widths
  // ====================
  localparam int COL_IDX_W   = $clog2(DEF_NUM_FEATURE_IN);
  // A full row holds NUM_FEATURE_IN entries, one more bit than the index
  localparam int ROW_LEN_W   = $clog2(DEF_NUM_FEATURE_IN) + 1;
  localparam int NUM_NODE_W  = $clog2(DEF_MAX_NODES + 1);
  localparam int ENTRY_W     = COL_IDX_W + DEF_DATA_WIDTH;
  localparam int NODE_INFO_W = ROW_LEN_W + NUM_NODE_W + 1;
  localparam int WH_W        = DEF_WH_DATA_WIDTH * DEF_NUM_FEATURE_OUT + NUM_NODE_W + 1;

  // Entry word {col, val}
  localparam int ENT_VAL_LSB = 0;
  localparam int ENT_COL_LSB = DEF_DATA_WIDTH;

  // Node info word {row_len, num_node, flag}
  localparam int NI_FLAG_BIT = 0;
  localparam int NI_NODE_LSB = 1;
  localparam int NI_LEN_LSB  = NI_NODE_LSB + NUM_NODE_W;

  // WH word {results, num_node, flag}
  localparam int WH_FLAG_BIT = 0;
  localparam int WH_NODE_LSB = 1;
  localparam int WH_RES_LSB  = WH_NODE_LSB + NUM_NODE_W;

endpackage

// ==== hdl/spmm_top.sv ====
`timescale 1ns/1ps

module spmm_top
  import spmm_dims_pkg::*;
  import spmm_layout_pkg::*;
#(
  parameter int DATA_WIDTH      = DEF_DATA_WIDTH,
  parameter int WH_DATA_WIDTH   = DEF_WH_DATA_WIDTH,
  parameter int NUM_FEATURE_IN  = DEF_NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT = DEF_NUM_FEATURE_OUT,
  parameter int NUM_ROWS        = DEF_NUM_ROWS,
  parameter int FIFO_DEPTH      = DEF_FIFO_DEPTH
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start_req_i,
  output logic                                  start_ack_o,
  output logic [$clog2(NUM_ROWS)-1:0]           ni_addr_o,
  input  logic [NODE_INFO_W-1:0]                ni_data_i,
  output logic [H_ADDR_W-1:0]                   h_addr_o,
  input  logic [ENTRY_W-1:0]                    h_data_i,
  output logic [COL_IDX_W-1:0]                  w_row_addr_o,
  input  logic [NUM_FEATURE_OUT*DATA_WIDTH-1:0] w_row_data_i,
  output logic                                  wh_we_o,
  output logic [$clog2(NUM_ROWS)-1:0]           wh_addr_o,
  output logic [WH_W-1:0]                       wh_data_o
);

  logic                                     entry_vld;
  logic                                     entry_first;
  logic                                     entry_last;
  logic                                     fifo_push;
  logic                                     fifo_pop;
  logic [NODE_INFO_W-1:0]                   fifo_din;
  logic [NODE_INFO_W-1:0]                   fifo_dout;
  logic [NUM_FEATURE_OUT-1:0]               pe_vld;
  logic [NUM_FEATURE_OUT*WH_DATA_WIDTH-1:0] pe_res;

  // ====================
  // Control and tags
  // ====================
  spmm_ctrl #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .NUM_ROWS       (NUM_ROWS)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_req_i   (start_req_i),
    .start_ack_o   (start_ack_o),
    .ni_addr_o     (ni_addr_o),
    .ni_data_i     (ni_data_i),
    .h_addr_o      (h_addr_o),
    .w_row_addr_o  (w_row_addr_o),
    .h_data_i      (h_data_i),
    .entry_vld_o   (entry_vld),
    .entry_first_o (entry_first),
    .entry_last_o  (entry_last),
    .fifo_push_o   (fifo_push),
    .fifo_din_o    (fifo_din),
    .fifo_pop_o    (fifo_pop),
    .row_done_i    (pe_vld[0])
  );

  node_info_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (fifo_push),
    .din_i   (fifo_din),
    .pop_i   (fifo_pop),
    .dout_o  (fifo_dout),
    .empty_o (),
    .full_o  ()
  );

  // ====================
  // Element array
  // ====================
  for (genvar i = 0; i < NUM_FEATURE_OUT; i++) begin : g_pe
    sparse_pe #(
      .DATA_WIDTH    (DATA_WIDTH),
      .WH_DATA_WIDTH (WH_DATA_WIDTH)
    ) u_pe (
      .clk           (clk),
      .rst_n         (rst_n),
      .entry_vld_i   (entry_vld),
      .entry_first_i (entry_first),
      .entry_last_i  (entry_last),
      .val_i         (h_data_i[ENT_VAL_LSB +: DATA_WIDTH]),
      .wgt_i         (w_row_data_i[i * DATA_WIDTH +: DATA_WIDTH]),
      .res_vld_o     (pe_vld[i]),
      .res_o         (pe_res[i * WH_DATA_WIDTH +: WH_DATA_WIDTH])
    );
  end

  // Address rewinds during ack, ahead of the next run
  wh_writer #(
    .WH_DATA_WIDTH   (WH_DATA_WIDTH),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .NUM_ROWS        (NUM_ROWS)
  ) u_writer (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_vld_i   (pe_vld[0]),
    .res_i       (pe_res),
    .tag_i       (fifo_dout),
    .run_start_i (start_ack_o),
    .wh_we_o     (wh_we_o),
    .wh_addr_o   (wh_addr_o),
    .wh_data_o   (wh_data_o)
  );

endmodule

// ==== hdl/wh_writer.sv ====
`timescale 1ns/1ps

module wh_writer
  import spmm_dims_pkg::*;
  import spmm_layout_pkg::*;
#(
  parameter int WH_DATA_WIDTH   = DEF_WH_DATA_WIDTH,
  parameter int NUM_FEATURE_OUT = DEF_NUM_FEATURE_OUT,
  parameter int NUM_ROWS        = DEF_NUM_ROWS
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     res_vld_i,
  input  logic [NUM_FEATURE_OUT*WH_DATA_WIDTH-1:0] res_i,
  input  logic [NODE_INFO_W-1:0]                   tag_i,
  input  logic                                     run_start_i,
  output logic                                     wh_we_o,
  output logic [$clog2(NUM_ROWS)-1:0]              wh_addr_o,
  output logic [WH_W-1:0]                          wh_data_o
);

  logic [$clog2(NUM_ROWS)-1:0] wh_addr_q;

  // Feature 0 lands in the top result slot
  always_comb begin
    wh_data_o = '0;
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      wh_data_o[WH_RES_LSB + (NUM_FEATURE_OUT - 1 - i) * WH_DATA_WIDTH +: WH_DATA_WIDTH] =
        res_i[i * WH_DATA_WIDTH +: WH_DATA_WIDTH];
    end
    wh_data_o[WH_NODE_LSB +: NUM_NODE_W] = tag_i[NI_NODE_LSB +: NUM_NODE_W];
    wh_data_o[WH_FLAG_BIT]               = tag_i[NI_FLAG_BIT];
  end

  assign wh_we_o   = res_vld_i;
  assign wh_addr_o = wh_addr_q;

  // Address moves on after each write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_addr_q <= '0;
    end else if (run_start_i) begin
      wh_addr_q <= '0;
    end else if (res_vld_i) begin
      wh_addr_q <= wh_addr_q + 1'b1;
    end
  end

endmodule

// ==== testbench/spmm_golden.txt ====
// Hex words. @0 weights per H column {f3, f2, f1, f0}, one byte each
// Per run: node info {len, nodes, flag} at base, results f0 f1 f2 f3 per row at base+8,
// entries {col, val} at base+30
@0
02ff0001 02ff0101 02ff0201 02ff0301
02ff0401 02ff0501 02ff0601 02ff0701
02ff0801 02ff0901 02ff0a01 02ff0b01
02ff0c01 02ff0d01 02ff0e01 02ff0f01
// Run 0
@20
027 21e 022 06f 040 033 088 039
@28
00005 0000f ffffb 0000a
00010 00078 ffff0 00020
ffffe fffe2 00002 ffffc
0000b 0000f ffff5 00016
000fe 002fa fff02 001fc
fff80 fff80 00080 fff00
00006 0002c ffffa 0000c
00006 00048 ffffa 0000c
@50
305
001 101 201 301 401 501 601 701 801 901 a01 b01 c01 d01 e01 f01
ffe
00a 7fd 904
27f 47f
180
502 602 8ff a03
c06
// Run 1
@80
205 03f 021 20a 02c 043 030 03d
@88
00020 000f0 fffe0 00040
fffff 00000 00001 ffffe
0007f 00771 fff81 000fe
ffff0 fff88 00010 fffe0
00003 00018 ffffd 00006
fffff fffe5 00001 ffffe
fff80 ffd00 00080 fff00
0000a 0006e ffff6 00014
@b0
002 102 202 302 402 502 602 702 802 902 a02 b02 c02 d02 e02 f02
0ff
f7f
0ff 1ff 2ff 3ff 4ff 5ff 6ff 7ff 8ff 9ff aff bff cff dff eff fff
803
101 efe
680
b0a

// ==== testbench/tb_spmm_tasks.svh ====
`ifndef TB_SPMM_TASKS_SVH
`define TB_SPMM_TASKS_SVH

// ====================
// Checks
// ====================
task automatic check_value(input string name, input logic [WH_W-1:0] expected,
                           input logic [WH_W-1:0] actual);
  if (expected !== actual) begin
    errors++;
    $display("Error: %s expected %h actual %h", name, expected, actual);
  end
endtask

task automatic report_failure(input string msg);
  errors++;
  $display("%s", msg);
endtask

// ====================
// Golden data
// ====================
// Unused words hold a pattern built from their own address
task automatic load_golden();
  for (int i = 0; i < GOLD_DEPTH; i++) begin
    gold[i] = {4{8'(i)}} ^ 32'ha5a5_a5a5;
  end
  $readmemh("testbench/spmm_golden.txt", gold);
endtask

// Row length sits in the top bits of a node-info word
function automatic int row_entry_total(input int base);
  int total;
  total = 0;
  for (int r = 0; r < NUM_ROWS; r++) begin
    total += int'(gold[base + r][NODE_INFO_W-1 -: ROW_LEN_W]);
  end
  return total;
endfunction

// Feature 0 on top, then node count and flag as in the node-info word
function automatic logic [WH_W-1:0] expected_word(input int base, input int row);
  logic [WH_W-1:0] w;
  int              idx;
  w = '0;
  for (int f = 0; f < DEF_NUM_FEATURE_OUT; f++) begin
    idx = base + EXP_OFS + row * DEF_NUM_FEATURE_OUT + f;
    w[WH_W-1 - f*DEF_WH_DATA_WIDTH -: DEF_WH_DATA_WIDTH] = gold[idx][DEF_WH_DATA_WIDTH-1:0];
  end
  w[NUM_NODE_W:0] = gold[base + row][NUM_NODE_W:0];
  return w;
endfunction

// ====================
// One run through the req/ack handshake
// ====================
task automatic run_once(input int r);
  int limit;
  int cycles;
  int hold;
  int err_before;
  err_before = errors;
  cur_run    = r;
  cur_base   = (r == 0) ? RUN0_BASE : RUN1_BASE;
  limit      = row_entry_total(cur_base) * 4 + RUN_MARGIN;
  wr_count   = 0;
  early_ack  = 1'b0;
  @(negedge clk);
  in_run    = 1'b1;
  start_req = 1'b1;
  cycles    = 0;
  while (!start_ack && cycles < limit) begin
    @(negedge clk);
    cycles++;
  end
  if (!start_ack) begin
    report_failure($sformatf("Run %0d: start_ack_o never rose within %0d cycles", r, limit));
  end else begin
    check_value($sformatf("run%0d write count", r), WH_W'(NUM_ROWS), WH_W'(wr_count));
    hold = $urandom % 4;
    repeat (hold) begin
      @(negedge clk);
      if (!start_ack) begin
        report_failure($sformatf("Run %0d: start_ack_o fell while req was held", r));
      end
    end
    start_req = 1'b0;
    @(negedge clk);
    if (start_ack) begin
      report_failure($sformatf("Run %0d: start_ack_o did not fall after req dropped", r));
    end
  end
  start_req = 1'b0;
  in_run    = 1'b0;
  repeat ($urandom % 5 + 1) @(negedge clk);
  $display("Test run%0d: %0d writes, %0d errors", r, wr_count, errors - err_before);
endtask

`endif

// ==== testbench/tb_spmm.sv ====
`timescale 1ns/1ps

module tb_spmm
  import spmm_dims_pkg::*;
  import spmm_layout_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS   = DEF_NUM_ROWS;
  localparam int ROW_W      = $clog2(NUM_ROWS);
  localparam int GOLD_DEPTH = 256;
  // Word offsets inside the golden image
  localparam int RUN0_BASE  = 'h20;
  localparam int RUN1_BASE  = 'h80;
  localparam int EXP_OFS    = 'h08;
  localparam int ENT_OFS    = 'h30;
  localparam int RUN_MARGIN = 60;

  logic                                      clk;
  logic                                      rst_n;
  logic                                      start_req;
  logic                                      start_ack;
  logic [ROW_W-1:0]                          ni_addr;
  logic [NODE_INFO_W-1:0]                    ni_data;
  logic [H_ADDR_W-1:0]                       h_addr;
  logic [ENTRY_W-1:0]                        h_data;
  logic [COL_IDX_W-1:0]                      w_row_addr;
  logic [DEF_NUM_FEATURE_OUT*DEF_DATA_WIDTH-1:0] w_row_data;
  logic                                      wh_we;
  logic [ROW_W-1:0]                          wh_addr;
  logic [WH_W-1:0]                           wh_data;

  logic [31:0]          gold [GOLD_DEPTH];
  logic [ROW_W-1:0]     ni_a_q;
  logic [H_ADDR_W-1:0]  h_a_q;
  logic [COL_IDX_W-1:0] w_a_q;
  int                   cur_run;
  int                   cur_base;
  int                   wr_count;
  int                   errors;
  bit                   in_run;
  bit                   early_ack;
  bit                   loaded;

  `include "tb_spmm_tasks.svh"

  spmm_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_req_i  (start_req),
    .start_ack_o  (start_ack),
    .ni_addr_o    (ni_addr),
    .ni_data_i    (ni_data),
    .h_addr_o     (h_addr),
    .h_data_i     (h_data),
    .w_row_addr_o (w_row_addr),
    .w_row_data_i (w_row_data),
    .wh_we_o      (wh_we),
    .wh_addr_o    (wh_addr),
    .wh_data_o    (wh_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ====================
  // Memory models
  // ====================
  // Address taken at the rising edge and data driven on the next falling edge
  always @(posedge clk) begin
    ni_a_q <= ni_addr;
    h_a_q  <= h_addr;
    w_a_q  <= w_row_addr;
  end

  always @(negedge clk) begin
    ni_data    <= gold[cur_base + int'(ni_a_q)][NODE_INFO_W-1:0];
    h_data     <= gold[cur_base + ENT_OFS + int'(h_a_q)][ENTRY_W-1:0];
    w_row_data <= gold[int'(w_a_q)];
  end

  // WH writes checked in the middle of the cycle
  always @(negedge clk) begin
    if (rst_n && wh_we) begin
      if (!in_run || wr_count >= NUM_ROWS) begin
        report_failure($sformatf("Unexpected WH write at address %0d", wh_addr));
      end else begin
        check_value($sformatf("run%0d write %0d address", cur_run, wr_count),
                    WH_W'(wr_count), WH_W'(wh_addr));
        check_value($sformatf("run%0d write %0d data", cur_run, wr_count),
                    expected_word(cur_base, wr_count), wh_data);
        wr_count++;
      end
    end
    if (in_run && start_ack && wr_count < NUM_ROWS && !early_ack) begin
      early_ack = 1'b1;
      report_failure("start_ack_o rose before the last WH write of the run");
    end
  end

  // Watchdog scaled by the entry count of both runs
  initial begin
    int wd_cycles;
    wait (loaded);
    wd_cycles = (row_entry_total(RUN0_BASE) + row_entry_total(RUN1_BASE)) * 4
                + 2 * RUN_MARGIN + 40;
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles", wd_cycles);
    $display("Test failed");
    $finish;
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    rst_n      = 1'b0;
    start_req  = 1'b0;
    ni_data    = '0;
    h_data     = '0;
    w_row_data = '0;
    cur_run    = 0;
    cur_base   = RUN0_BASE;
    wr_count   = 0;
    errors     = 0;
    in_run     = 1'b0;
    early_ack  = 1'b0;
    loaded     = 1'b0;
    void'($urandom(32'h7a6d_3643));
    load_golden();
    loaded = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (start_ack) begin
      report_failure("start_ack_o is high after reset");
    end
    run_once(0);
    run_once(1);
    $display("Summary: 2 runs, %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+testbench
hdl/spmm_dims_pkg.sv
hdl/spmm_layout_pkg.sv
hdl/node_info_fifo.sv
hdl/sparse_pe.sv
hdl/wh_writer.sv
hdl/spmm_ctrl.sv
hdl/spmm_top.sv
testbench/tb_spmm.sv
